/* hdl/lc4_pkg.sv */
//====================================================================
// LC4 core shared definitions
// Word and register types, instruction fields and opcodes
//====================================================================
`default_nettype none

package lc4_pkg;

   typedef logic [15:0] word_t;     // Insn, address or register value
   typedef logic [2:0]  reg_idx_t;  // Register number
   typedef logic [3:0]  opcode_t;   // Top four insn bits

   localparam int NUM_REGS = 8;     // R0 to R7

   //====================================================================
   // Opcodes and sub-ops
   //====================================================================
   localparam opcode_t OP_ARITH = 4'b0001;  // ADD, SUB and ADD immediate
   localparam opcode_t OP_AND   = 4'b0101;
   localparam opcode_t OP_LDR   = 4'b0110;
   localparam opcode_t OP_STR   = 4'b0111;
   localparam opcode_t OP_CONST = 4'b1001;

   localparam logic [2:0] SUBOP_ADD = 3'b000;  // Bits 5:3
   localparam logic [2:0] SUBOP_SUB = 3'b010;
   localparam int         IMM_SEL_BIT = 5;      // Set for immediate form

   //====================================================================
   // Field positions
   //====================================================================
   localparam int OPC_HI  = 15;
   localparam int OPC_LO  = 12;
   localparam int RD_HI   = 11;  // Also STR source register
   localparam int RD_LO   = 9;
   localparam int RS_HI   = 8;
   localparam int RS_LO   = 6;
   localparam int SUB_HI  = 5;
   localparam int SUB_LO  = 3;
   localparam int RT_HI   = 2;
   localparam int RT_LO   = 0;
   localparam int IMM5_HI = 4;   // All immediates start at bit 0
   localparam int IMM6_HI = 5;
   localparam int IMM9_HI = 8;

endpackage

`default_nettype wire

/* hdl/lc4_pipe_if.sv */
//====================================================================
// LC4 pipeline bundles
// Decode to execute, execute to memory and writeback buses
//====================================================================
`timescale 1ns/10ps
`default_nettype none

// Decode-to-execute register contents
interface lc4_dx_if import lc4_pkg::*; ();
   word_t    insn;
   word_t    rs_data;    // After WD bypass
   word_t    rt_data;
   reg_idx_t rs;
   reg_idx_t rt;         // Data register for STR
   reg_idx_t rd;
   logic     reg_we;
   logic     is_load;
   logic     is_store;

   modport driver (output insn, rs_data, rt_data, rs, rt, rd, reg_we, is_load, is_store);
   modport reader (input  insn, rs_data, rt_data, rs, rt, rd, reg_we, is_load, is_store);
endinterface

// Execute-to-memory register contents
interface lc4_xm_if import lc4_pkg::*; ();
   word_t    alu_result;  // Result or memory address
   word_t    store_data;
   reg_idx_t rt;
   reg_idx_t rd;
   logic     reg_we;
   logic     is_load;
   logic     is_store;

   modport driver (output alu_result, store_data, rt, rd, reg_we, is_load, is_store);
   modport reader (input  alu_result, store_data, rt, rd, reg_we, is_load, is_store);
endinterface

// Writeback port, also the source of WD, WX and WM bypass
interface lc4_wb_if import lc4_pkg::*; ();
   logic     wb_we;
   reg_idx_t wb_rd;
   word_t    wb_data;     // Load data or ALU result
   logic     wb_is_load;

   modport driver (output wb_we, wb_rd, wb_data, wb_is_load);
   modport reader (input  wb_we, wb_rd, wb_data, wb_is_load);
endinterface

`default_nettype wire

/* hdl/lc4_fetch.sv */
//====================================================================
// LC4 fetch stage
// Program counter and fetch-to-decode insn register
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_fetch import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200   // First fetch address
) (
   input  wire        gwe,
   input  wire        i_rst,
   input  wire        i_stall,       // Load-use hold
   input  wire word_t i_imem_insn,   // Insn at o_pc, same cycle
   output word_t      o_pc,
   output word_t      o_insn         // Insn now in decode
);

   word_t pc;
   word_t pc_next;

   assign pc_next = pc + word_t'(1);  // No branches, always sequential
   assign o_pc    = pc;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc     <= RESET_PC;
         o_insn <= '0;                 // All-zero word decodes as no-op
      end else if (!i_stall) begin
         pc     <= pc_next;
         o_insn <= i_imem_insn;        // Capture at end of fetch cycle
      end
      // Stalled: PC and decode insn both hold
   end

endmodule

`default_nettype wire

/* hdl/lc4_regfile.sv */
//====================================================================
// LC4 register file
// Eight words, two combinational reads, one write from writeback
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
   input  wire           gwe,
   input  wire           i_rst,
   input  wire reg_idx_t i_rs,
   input  wire reg_idx_t i_rt,
   output word_t         o_rs_data,
   output word_t         o_rt_data,
   lc4_wb_if.reader      wb
);

   word_t regs [NUM_REGS];

   // Write at end of writeback cycle
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.wb_we) begin
         regs[wb.wb_rd] <= wb.wb_data;
      end
   end

   // Reads see old value; decode adds WD bypass
   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

endmodule

`default_nettype wire

/* hdl/lc4_decode.sv */
//====================================================================
// LC4 decode stage
// Field decode, WD bypass, load-use stall and decode-to-execute
// pipeline register
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_decode import lc4_pkg::*; (
   input  wire           gwe,
   input  wire           i_rst,
   input  wire word_t    i_insn,      // From fetch register
   output reg_idx_t      o_rs,        // Register file read selects
   output reg_idx_t      o_rt,
   input  wire word_t    i_rs_data,
   input  wire word_t    i_rt_data,
   output logic          o_stall,     // Load-use hazard
   lc4_dx_if.driver      dx,
   lc4_wb_if.reader      wb
);

   opcode_t    opc;
   logic [2:0] subop;
   logic       is_arith_imm;
   logic       is_arith_reg;
   logic       is_and;
   logic       is_const;
   logic       is_load;
   logic       is_store;
   logic       reg_we;
   logic       rs_re;          // Insn really reads rs
   logic       rt_re;          // Insn really reads rt
   reg_idx_t   rs;
   reg_idx_t   rt;
   reg_idx_t   rd;
   word_t      rs_data;
   word_t      rt_data;

   //====================================================================
   // Insn classes
   //====================================================================
   assign opc   = i_insn[OPC_HI:OPC_LO];
   assign subop = i_insn[SUB_HI:SUB_LO];

   assign is_arith_imm = (opc == OP_ARITH) && i_insn[IMM_SEL_BIT];
   assign is_arith_reg = (opc == OP_ARITH) && !i_insn[IMM_SEL_BIT] &&
                         ((subop == SUBOP_ADD) || (subop == SUBOP_SUB));  // MUL, DIV dropped
   assign is_and       = (opc == OP_AND) && (subop == SUBOP_ADD);  // Register AND uses 000 too
   assign is_const     = (opc == OP_CONST);
   assign is_load      = (opc == OP_LDR);
   assign is_store     = (opc == OP_STR);

   // Anything unlisted gets no write and retires as a no-op
   assign reg_we = is_arith_imm | is_arith_reg | is_and | is_const | is_load;
   assign rs_re  = is_arith_imm | is_arith_reg | is_and | is_load | is_store;
   assign rt_re  = is_arith_reg | is_and | is_store;

   assign rs = i_insn[RS_HI:RS_LO];
   assign rt = is_store ? i_insn[RD_HI:RD_LO] : i_insn[RT_HI:RT_LO];  // STR data reg
   assign rd = i_insn[RD_HI:RD_LO];

   assign o_rs = rs;
   assign o_rt = rt;

   // WD bypass, writeback value seen in the same cycle
   assign rs_data = (wb.wb_we && (wb.wb_rd == rs)) ? wb.wb_data : i_rs_data;
   assign rt_data = (wb.wb_we && (wb.wb_rd == rt)) ? wb.wb_data : i_rt_data;

   //====================================================================
   // Load-use hazard against the load now in execute
   //====================================================================
   // Store data match is left to WM bypass
   assign o_stall = dx.is_load && dx.reg_we &&
                    ((rs_re && (rs == dx.rd)) ||
                     (rt_re && !is_store && (rt == dx.rd)));

   always_ff @(posedge gwe) begin
      if (i_rst || o_stall) begin
         dx.insn     <= '0;          // Bubble into execute
         dx.reg_we   <= 1'b0;
         dx.is_load  <= 1'b0;
         dx.is_store <= 1'b0;
      end else begin
         dx.insn     <= i_insn;
         dx.reg_we   <= reg_we;
         dx.is_load  <= is_load;
         dx.is_store <= is_store;
      end
      dx.rs_data <= rs_data;         // Payload, qualified by flags
      dx.rt_data <= rt_data;
      dx.rs      <= rs;
      dx.rt      <= rt;
      dx.rd      <= rd;
   end

endmodule

`default_nettype wire

/* hdl/lc4_execute.sv */
//====================================================================
// LC4 execute stage
// MX/WX operand bypass, ALU and execute-to-memory register
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_execute import lc4_pkg::*; (
   input  wire       gwe,
   input  wire       i_rst,
   lc4_dx_if.reader  dx,
   lc4_xm_if.driver  xm,
   lc4_wb_if.reader  wb
);

   opcode_t    opc;
   logic [2:0] subop;
   word_t      rs_val;        // Bypassed operands
   word_t      rt_val;
   word_t      imm5_sx;
   word_t      imm6_sx;
   word_t      imm9_sx;
   word_t      alu_out;

   assign opc   = dx.insn[OPC_HI:OPC_LO];
   assign subop = dx.insn[SUB_HI:SUB_LO];

   // Sign-extended immediates
   assign imm5_sx = {{($bits(word_t)-IMM5_HI-1){dx.insn[IMM5_HI]}}, dx.insn[IMM5_HI:0]};
   assign imm6_sx = {{($bits(word_t)-IMM6_HI-1){dx.insn[IMM6_HI]}}, dx.insn[IMM6_HI:0]};
   assign imm9_sx = {{($bits(word_t)-IMM9_HI-1){dx.insn[IMM9_HI]}}, dx.insn[IMM9_HI:0]};

   //====================================================================
   // Bypass, MX over WX over registered
   //====================================================================
   // A load in memory only holds its address, so MX skips it
   assign rs_val = (xm.reg_we && !xm.is_load && (xm.rd == dx.rs)) ? xm.alu_result :
                   (wb.wb_we && (wb.wb_rd == dx.rs))               ? wb.wb_data    :
                                                                     dx.rs_data;
   assign rt_val = (xm.reg_we && !xm.is_load && (xm.rd == dx.rt)) ? xm.alu_result :
                   (wb.wb_we && (wb.wb_rd == dx.rt))               ? wb.wb_data    :
                                                                     dx.rt_data;

   always_comb begin
      case (opc)
         OP_ARITH: begin
            if (dx.insn[IMM_SEL_BIT])
               alu_out = rs_val + imm5_sx;        // ADD immediate
            else if (subop == SUBOP_SUB)
               alu_out = rs_val - rt_val;
            else
               alu_out = rs_val + rt_val;
         end
         OP_AND:         alu_out = rs_val & rt_val;
         OP_CONST:       alu_out = imm9_sx;
         OP_LDR, OP_STR: alu_out = rs_val + imm6_sx;  // Base plus offset
         default:        alu_out = '0;                // No-op
      endcase
   end

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         xm.reg_we   <= 1'b0;
         xm.is_load  <= 1'b0;
         xm.is_store <= 1'b0;
      end else begin
         xm.reg_we   <= dx.reg_we;
         xm.is_load  <= dx.is_load;
         xm.is_store <= dx.is_store;
      end
      xm.alu_result <= alu_out;
      xm.store_data <= rt_val;       // May still be fixed by WM
      xm.rt         <= dx.rt;
      xm.rd         <= dx.rd;
   end

endmodule

`default_nettype wire

/* hdl/lc4_memory.sv */
//====================================================================
// LC4 memory and writeback stages
// Data memory drive with WM bypass, writeback register and select
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_memory import lc4_pkg::*; (
   input  wire        gwe,
   input  wire        i_rst,
   lc4_xm_if.reader   xm,
   output word_t      o_dmem_addr,
   output logic       o_dmem_we,      // High for one cycle per store
   output word_t      o_dmem_wdata,
   input  wire word_t i_dmem_rdata,   // Combinational read
   lc4_wb_if.driver   wb
);

   word_t alu_q;       // Writeback copies
   word_t load_q;
   logic  wm_hit;

   //====================================================================
   // Memory stage
   //====================================================================
   // Store right behind a load of its data register
   assign wm_hit = xm.is_store && wb.wb_is_load && wb.wb_we && (wb.wb_rd == xm.rt);

   assign o_dmem_addr  = xm.alu_result;
   assign o_dmem_we    = xm.is_store;
   assign o_dmem_wdata = wm_hit ? wb.wb_data : xm.store_data;

   //====================================================================
   // Writeback stage
   //====================================================================
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         wb.wb_we      <= 1'b0;
         wb.wb_is_load <= 1'b0;
      end else begin
         wb.wb_we      <= xm.reg_we;
         wb.wb_is_load <= xm.is_load;
      end
      wb.wb_rd <= xm.rd;
      alu_q    <= xm.alu_result;
      load_q   <= i_dmem_rdata;      // Only meaningful for loads
   end

   assign wb.wb_data = wb.wb_is_load ? load_q : alu_q;  // Regfile write value

endmodule

`default_nettype wire

/* hdl/lc4_core.sv */
//====================================================================
// LC4 five-stage pipelined core
// Fetch, decode, execute, memory and writeback with bypassing
//====================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_core import lc4_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  wire        gwe,
   input  wire        i_rst,
   output word_t      o_imem_addr,
   input  wire word_t i_imem_insn,
   output word_t      o_dmem_addr,
   input  wire word_t i_dmem_rdata,
   output logic       o_dmem_we,
   output word_t      o_dmem_wdata
);

   word_t    d_insn;       // Insn in decode
   reg_idx_t rf_rs;        // Register file read selects
   reg_idx_t rf_rt;
   word_t    rf_rs_data;
   word_t    rf_rt_data;
   logic     stall;        // Load-use hold

   lc4_dx_if dx_bus ();
   lc4_xm_if xm_bus ();
   lc4_wb_if wb_bus ();

   lc4_fetch #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .gwe         (gwe),
      .i_rst       (i_rst),
      .i_stall     (stall),
      .i_imem_insn (i_imem_insn),
      .o_pc        (o_imem_addr),
      .o_insn      (d_insn)
   );

   lc4_decode u_decode (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_insn    (d_insn),
      .o_rs      (rf_rs),
      .o_rt      (rf_rt),
      .i_rs_data (rf_rs_data),
      .i_rt_data (rf_rt_data),
      .o_stall   (stall),
      .dx        (dx_bus.driver),
      .wb        (wb_bus.reader)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_rs      (rf_rs),
      .i_rt      (rf_rt),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data),
      .wb        (wb_bus.reader)
   );

   lc4_execute u_execute (
      .gwe   (gwe),
      .i_rst (i_rst),
      .dx    (dx_bus.reader),
      .xm    (xm_bus.driver),
      .wb    (wb_bus.reader)
   );

   lc4_memory u_memory (
      .gwe          (gwe),
      .i_rst        (i_rst),
      .xm           (xm_bus.reader),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .i_dmem_rdata (i_dmem_rdata),
      .wb           (wb_bus.driver)
   );

endmodule

`default_nettype wire

/* testbench/lc4_core_properties.sv */
//======================================================================
// LC4 core properties
// Stall and store checks, bound into the core
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_core_properties import lc4_pkg::*; (
   input wire        gwe,
   input wire        i_rst,
   input wire        stall,
   input wire word_t pc,
   input wire        dmem_we
);

   // PC holds across a load-use stall
   pc_hold: assert property (@(posedge gwe) disable iff (i_rst)
      stall |=> (pc == $past(pc)))
      else $error("PC moved during a stall");

   // One bubble per load-use hazard
   stall_once: assert property (@(posedge gwe) disable iff (i_rst)
      stall |=> !stall)
      else $error("Stall lasted two cycles");

   // Stage flags are cleared after the first reset edge
   no_store_in_reset: assert property (@(posedge gwe)
      (i_rst && $past(i_rst)) |-> !dmem_we)
      else $error("Store during reset");

endmodule

bind lc4_core lc4_core_properties u_props (
   .gwe     (gwe),
   .i_rst   (i_rst),
   .stall   (stall),
   .pc      (o_imem_addr),
   .dmem_we (o_dmem_we)
);

`default_nettype wire

/* testbench/lc4_core_tb.sv */
//======================================================================
// LC4 core testbench
// Program and expected stores come from a trace file; instruction and
// data memories are modeled here and every store is checked
//======================================================================
`timescale 1ns/10ps
`default_nettype none

module lc4_core_tb import lc4_pkg::*; ();

   localparam word_t RESET_PC     = 16'h8200;
   localparam int    CLK_PERIOD   = 100;    // ns
   localparam int    RESET_CYCLES = 4;
   localparam int    PIPE_DEPTH   = 3;      // Fetch to memory stage
   localparam int    DRAIN        = 8;      // Quiet cycles after last store
   localparam int    MAX_PROG     = 256;
   localparam int    MAX_STORES   = 64;
   localparam string TRACE_FILE   = "testbench/lc4_core_trace.txt";

   logic  gwe;
   logic  i_rst;
   word_t i_imem_insn;
   word_t i_dmem_rdata;
   word_t o_imem_addr;
   word_t o_dmem_addr;
   logic  o_dmem_we;
   word_t o_dmem_wdata;

   word_t imem [MAX_PROG];      // Program, index 0 at RESET_PC
   word_t dmem [65536];
   int    prog_len;

   // Expected stores, in order
   word_t exp_addr  [MAX_STORES];
   word_t exp_data  [MAX_STORES];
   int    exp_idx   [MAX_STORES];   // Program index of the STR
   int    exp_stall [MAX_STORES];   // Load-use stalls before it
   string exp_name  [MAX_STORES];
   int    n_stores;
   int    seen;                     // Stores checked so far
   int    cyc;                      // Cycles since reset release
   logic  loaded;

   lc4_core #(
      .RESET_PC (RESET_PC)
   ) dut (
      .gwe          (gwe),
      .i_rst        (i_rst),
      .o_imem_addr  (o_imem_addr),
      .i_imem_insn  (i_imem_insn),
      .o_dmem_addr  (o_dmem_addr),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata)
   );

   initial gwe = 1'b0;
   always #(CLK_PERIOD/2) gwe = ~gwe;

   //======================================================================
   // Helpers
   //======================================================================
   // Every address gets its own initial word
   function automatic word_t fill_word(input word_t a);
      return {a[7:0], a[15:8]} ^ 16'h3c5a;
   endfunction

   function automatic word_t fetch_word(input word_t addr);
      word_t off;
      off = addr - RESET_PC;           // Wraps below RESET_PC
      if (int'(off) < prog_len) return imem[off];
      return '0;                        // No-op outside the program
   endfunction

   // Memory stage of STR k, shifted by any stalls ahead of it
   function automatic int store_cycle(input int k);
      return exp_idx[k] + PIPE_DEPTH + exp_stall[k];
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input string what,
                             input word_t exp, input word_t act);
      assert (exp === act) else begin
         $display("[ERROR] %s: %s expected %h, actual %h", name, what, exp, act);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic read_trace();
      int    fd;
      int    rc;
      string line;
      word_t w;
      word_t a;
      int    idx;
      int    st;
      string name;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) fail_run("Could not open the trace file");
      prog_len = 0;
      n_stores = 0;
      while (!$feof(fd)) begin
         rc = $fgets(line, fd);
         if (rc > 0 && line.getc(0) == "P") begin
            rc = $sscanf(line, "P %h", w);
            imem[prog_len] = w;
            prog_len++;
         end else if (rc > 0 && line.getc(0) == "S") begin
            rc = $sscanf(line, "S %h %h %d %d %s", a, w, idx, st, name);
            exp_addr[n_stores]  = a;
            exp_data[n_stores]  = w;
            exp_idx[n_stores]   = idx;
            exp_stall[n_stores] = st;
            exp_name[n_stores]  = name;
            n_stores++;
         end
         // Comment and blank lines fall through
      end
      $fclose(fd);
      if (n_stores == 0) fail_run("The trace file holds no expected stores");
   endtask

   task automatic handle_store();
      if (seen >= n_stores) fail_run($sformatf("Unexpected store in cycle %0d", cyc));
      check_word(exp_name[seen], "store address", exp_addr[seen], o_dmem_addr);
      check_word(exp_name[seen], "store data", exp_data[seen], o_dmem_wdata);
      check_word(exp_name[seen], "store cycle", word_t'(store_cycle(seen)), word_t'(cyc));
      dmem[o_dmem_addr] = o_dmem_wdata;
      seen++;
   endtask

   //======================================================================
   // Main sequence, all inputs change on the falling edge
   //======================================================================
   initial begin
      i_rst        = 1'b1;
      i_imem_insn  = '0;
      i_dmem_rdata = '0;
      loaded       = 1'b0;
      seen         = 0;
      cyc          = 0;
      for (int a = 0; a < 65536; a++) begin
         dmem[a] = fill_word(word_t'(a));
      end
      read_trace();
      loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge gwe);
      @(negedge gwe);
      i_rst = 1'b0;
      check_word("reset", "first fetch address", RESET_PC, o_imem_addr);

      while (cyc <= store_cycle(n_stores-1) + DRAIN) begin
         if (o_dmem_we) handle_store();   // Write before read, same edge
         i_imem_insn  = fetch_word(o_imem_addr);
         i_dmem_rdata = dmem[o_dmem_addr];
         @(negedge gwe);
         cyc++;
      end

      if (seen != n_stores) begin
         $display("Only %0d of %0d expected stores appeared", seen, n_stores);
         $display("Done: errors found");
         $fatal(1);
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

   // Watchdog sized from the program and the stalls in it
   initial begin
      int limit;
      wait (loaded);
      limit = RESET_CYCLES + prog_len + PIPE_DEPTH + exp_stall[n_stores-1] + DRAIN + 16;
      #(limit * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, simulation did not finish", limit);
      $display("Done: errors found");
      $fatal(1);
   end

endmodule

`default_nettype wire

/* testbench/lc4_core_trace.txt */
# P insn          program word, first one at RESET_PC
# S addr data idx stalls name   expected store; idx is the STR's program index
P 0000
P 0000
P 920C
P 95FD
P 9E20
P 1642
P 77C0
P 1852
P 79C1
P 5A42
P 7BC2
P 1C7B
P 7DC3
P 1241
P 1441
P 1642
P 77C4
P 69C0
P 79C5
P 6BC1
P 1D41
P 7DC6
P 0000
P 0000
S 0020 0009 6 0 add_reg
S 0021 000F 8 0 sub_reg
S 0022 000C 10 0 and_reg
S 0023 0007 12 0 add_imm
S 0024 0048 16 0 mx_wx_chain
S 0025 0009 18 0 load_store_wm
S 0026 0027 21 1 load_use_stall

/* lc4_core.f */
hdl/lc4_pkg.sv
hdl/lc4_pipe_if.sv
hdl/lc4_fetch.sv
hdl/lc4_regfile.sv
hdl/lc4_decode.sv
hdl/lc4_execute.sv
hdl/lc4_memory.sv
hdl/lc4_core.sv
testbench/lc4_core_properties.sv
testbench/lc4_core_tb.sv

/* Makefile */
# Verilator build for the LC4 pipelined core

VERILATOR ?= verilator
FILELIST  ?= lc4_core.f
TOP       ?= lc4_core_tb
RTL_TOP   ?= lc4_core
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
